//--- tb.f
+incdir+test
verilog/radio_pkg.sv
verilog/radio_settings.sv
verilog/timekeeper.sv
verilog/tx_frontend.sv
verilog/rx_frontend.sv
verilog/readback_mux.sv
verilog/radio_core.sv
test/tb_radio_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_radio_core
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/radio_model.svh
// Radio core reference model

// Registers mirrored from the design and updated once per rising edge
logic                 m_loopback;
radio_pkg::set_data_t m_test_word;
radio_pkg::iq_t       m_idle_word;
radio_pkg::rb_sel_t   m_rb_sel;
radio_pkg::set_data_t m_time_hi;
radio_pkg::set_data_t m_time_lo;
radio_pkg::time_t     m_time_value;
logic                 m_load_now;
logic                 m_load_pps;
logic                 m_pps_sync;
logic                 m_pps_prev;
logic                 m_load_pending;
radio_pkg::time_t     m_vita_time;
radio_pkg::time_t     m_vita_time_pps;
radio_pkg::iq_t       m_held;
radio_pkg::iq_t       m_tx;
radio_pkg::iq_t       m_rx_sample;
logic                 m_rx_strobe;
radio_pkg::rb_word_t  m_rb_data;

task automatic model_reset();
   m_loopback      = 1'b0;
   m_test_word     = '0;
   m_idle_word     = '0;
   m_rb_sel        = '0;
   m_time_hi       = '0;
   m_time_lo       = '0;
   m_time_value    = '0;
   m_load_now      = 1'b0;
   m_load_pps      = 1'b0;
   m_pps_sync      = 1'b0;
   m_pps_prev      = 1'b0;
   m_load_pending  = 1'b0;
   m_vita_time     = '0;
   m_vita_time_pps = '0;
   m_held          = '0;
   m_tx            = '0;
   m_rx_sample     = '0;
   m_rx_strobe     = 1'b0;
   m_rb_data       = '0;
endtask

// Each register is written only after every reader has used its old value
task automatic model_step();
   logic           pps_edge;
   radio_pkg::iq_t rx_sel;
   radio_pkg::iq_t held_next;
   if (rst) begin
      model_reset();
   end else begin
      case (m_rb_sel)
         radio_pkg::RB_TEST:     m_rb_data = {32'd0, m_test_word};
         radio_pkg::RB_TIME:     m_rb_data = m_vita_time;
         radio_pkg::RB_TIME_PPS: m_rb_data = m_vita_time_pps;
         radio_pkg::RB_FRONTEND: m_rb_data = {m_tx, rx_word};
         radio_pkg::RB_STATUS:   m_rb_data = {61'd0, run_tx, run_rx, m_loopback};
         default:                m_rb_data = '0;
      endcase

      // Loopback sees the DAC word from before this edge
      rx_sel      = m_loopback ? m_tx : rx_word;
      rx_sel[16]  = fp_gpio[0] ^ fp_gpio[8];
      rx_sel[0]   = fp_gpio[1] ^ fp_gpio[9];
      m_rx_sample = rx_sel;
      m_rx_strobe = run_rx;

      held_next = tx_strobe ? tx_sample : m_held;
      m_tx      = run_tx ? held_next : m_idle_word;
      m_held    = held_next;

      pps_edge = m_pps_sync & ~m_pps_prev;
      if (pps_edge)
         m_vita_time_pps = m_vita_time;
      if (m_load_now || (pps_edge && m_load_pending))
         m_vita_time = m_time_value;
      else
         m_vita_time = m_vita_time + 64'd1;
      if (m_load_now)
         m_load_pending = 1'b0;
      else if (m_load_pps)
         m_load_pending = 1'b1;
      else if (pps_edge)
         m_load_pending = 1'b0;
      m_pps_prev = m_pps_sync;
      m_pps_sync = pps;

      m_load_now = 1'b0;
      m_load_pps = 1'b0;
      if (set_stb) begin
         if (set_addr == radio_pkg::SR_LOOPBACK)
            m_loopback = set_data[0];
         else if (set_addr == radio_pkg::SR_TEST)
            m_test_word = set_data;
         else if (set_addr == radio_pkg::SR_CODEC_IDLE)
            m_idle_word = set_data;
         else if (set_addr == radio_pkg::SR_READBACK)
            m_rb_sel = set_data[2:0];
         else if (set_addr == TIME_BASE)
            m_time_hi = set_data;
         else if (set_addr == TIME_BASE + 8'd1)
            m_time_lo = set_data;
         else if (set_addr == TIME_BASE + 8'd2) begin
            m_time_value = {m_time_hi, m_time_lo};
            m_load_now   = set_data[radio_pkg::TIME_CTRL_NOW];
            m_load_pps   = ~set_data[radio_pkg::TIME_CTRL_NOW];
         end
      end
   end
endtask

//--- test/tb_radio_core.sv
// Radio core testbench

`timescale 1ns/1ps

module tb_radio_core;

   localparam int CLK_HALF     = 50;
   localparam int RESET_CYCLES = 8;
   localparam int N_REG        = 40;
   localparam int N_TX         = 60;
   localparam int N_RX         = 60;
   localparam int NOW_REPS     = 3;
   localparam int COUNT_CYCLES = 20;
   localparam int PPS_REPS     = 4;
   localparam int PPS_GAP      = 5;
   localparam int PPS_HIGH     = 6;
   localparam int PPS_LOW      = 12;
   localparam int N_MIX        = 80;
   localparam int TEST_COUNT   = 6;
   localparam int NOW_CYCLES   = NOW_REPS * (4 + COUNT_CYCLES);
   localparam int PPS_CYCLES   = 1 + PPS_REPS * (3 + PPS_GAP + PPS_HIGH + PPS_LOW);
   localparam int TOTAL_CYCLES = RESET_CYCLES + N_REG + N_TX + N_RX + NOW_CYCLES
                                 + PPS_CYCLES + N_MIX;
   localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 100;
   localparam radio_pkg::set_addr_t TIME_BASE = radio_pkg::SR_TIME;

   logic                  radio_clk;
   logic                  rst;
   logic                  set_stb;
   radio_pkg::set_addr_t  set_addr;
   radio_pkg::set_data_t  set_data;
   radio_pkg::iq_t        rx_word;
   logic [9:0]            fp_gpio;
   logic                  pps;
   logic                  run_tx;
   logic                  run_rx;
   logic                  tx_strobe;
   radio_pkg::iq_t        tx_sample;
   radio_pkg::iq_t        dut_tx;
   radio_pkg::iq_t        dut_rx_sample;
   logic                  dut_rx_strobe;
   radio_pkg::time_t      dut_vita_time;
   radio_pkg::rb_word_t   dut_rb_data;

   logic [31:0] lcg_state;
   int          test_checks;
   int          test_errors;
   int          total_checks;
   int          total_errors;
   int          tests_passed;

   `include "radio_model.svh"

   radio_core #(
      .SR_TIME_BASE (TIME_BASE)
   ) u_radio_core (
      .radio_clk   (radio_clk),
      .i_rst       (rst),
      .i_set_stb   (set_stb),
      .i_set_addr  (set_addr),
      .i_set_data  (set_data),
      .i_rx        (rx_word),
      .i_fp_gpio   (fp_gpio),
      .i_pps       (pps),
      .i_run_tx    (run_tx),
      .i_run_rx    (run_rx),
      .i_tx_strobe (tx_strobe),
      .i_tx_sample (tx_sample),
      .o_tx        (dut_tx),
      .o_rx_sample (dut_rx_sample),
      .o_rx_strobe (dut_rx_strobe),
      .o_vita_time (dut_vita_time),
      .o_rb_data   (dut_rb_data)
   );

   always #(CLK_HALF) radio_clk = ~radio_clk;

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // Upper state bits folded down, the low LCG bits alone repeat quickly
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state ^ (lcg_state >> 16);
   endfunction

   task automatic compare(input string test, input string what,
                          input logic [63:0] expected, input logic [63:0] actual);
      test_checks++;
      if (expected !== actual) begin
         test_errors++;
         $display("ERR %s %s: expected %h, actual %h", test, what, expected, actual);
      end
   endtask

   // Model advances on the same edge as the DUT before the inputs change
   task automatic edge_step();
      @(posedge radio_clk);
      model_step();
   endtask

   task automatic check_outputs(input string test);
      @(negedge radio_clk);
      compare(test, "o_tx", {32'd0, m_tx}, {32'd0, dut_tx});
      compare(test, "o_rx_sample", {32'd0, m_rx_sample}, {32'd0, dut_rx_sample});
      compare(test, "o_rx_strobe", {63'd0, m_rx_strobe}, {63'd0, dut_rx_strobe});
      compare(test, "o_vita_time", m_vita_time, dut_vita_time);
      compare(test, "o_rb_data", m_rb_data, dut_rb_data);
   endtask

   task automatic drive_write(input radio_pkg::set_addr_t addr, input radio_pkg::set_data_t data);
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
   endtask

   task automatic drive_idle();
      set_stb <= 1'b0;
   endtask

   task automatic drive_random_io();
      logic [31:0] r;
      r = lcg_next();
      rx_word   <= lcg_next();
      tx_sample <= lcg_next();
      fp_gpio   <= r[9:0];
      // Transmit runs about three quarters of the time
      run_tx    <= r[12] | r[13];
      run_rx    <= r[14];
      tx_strobe <= r[15];
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0)
         tests_passed++;
      total_checks += test_checks;
      total_errors += test_errors;
      $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_register();
      logic [31:0]        r;
      radio_pkg::rb_sel_t sel_code;
      int                 i;
      sel_code = radio_pkg::RB_TEST;
      for (i = 0; i < N_REG; i++) begin
         edge_step();
         r = lcg_next();
         drive_random_io();
         // Select codes taken in turn so every unused one is read as well
         if (i % 4 == 1) begin
            drive_write(radio_pkg::SR_READBACK, {29'd0, sel_code});
            sel_code = sel_code + 3'd1;
         end else if (i % 4 == 2 || r[0])
            drive_write(radio_pkg::SR_TEST, lcg_next());
         else
            drive_idle();
         check_outputs("test_register");
      end
      finish_test("test_register");
   endtask

   task automatic test_tx_word();
      logic [31:0] r;
      int          i;
      for (i = 0; i < N_TX; i++) begin
         edge_step();
         r = lcg_next();
         drive_random_io();
         if (i == 0)
            drive_write(radio_pkg::SR_READBACK, {29'd0, radio_pkg::RB_FRONTEND});
         else if (r[2:0] == 3'd0)
            drive_write(radio_pkg::SR_CODEC_IDLE, lcg_next());
         else
            drive_idle();
         check_outputs("tx_word");
      end
      finish_test("tx_word");
   endtask

   task automatic test_rx_word();
      logic [31:0] r;
      int          i;
      for (i = 0; i < N_RX; i++) begin
         edge_step();
         r = lcg_next();
         drive_random_io();
         if (r[1:0] == 2'd0)
            drive_write(radio_pkg::SR_LOOPBACK, {31'd0, r[8]});
         else
            drive_idle();
         check_outputs("rx_word");
      end
      finish_test("rx_word");
   endtask

   task automatic test_time_now();
      radio_pkg::time_t value;
      radio_pkg::time_t expect_time;
      int               rep;
      int               k;
      for (rep = 0; rep < NOW_REPS; rep++) begin
         value = {lcg_next(), lcg_next()};
         edge_step();
         drive_write(TIME_BASE, value[63:32]);
         check_outputs("time_now");
         edge_step();
         drive_write(TIME_BASE + 8'd1, value[31:0]);
         check_outputs("time_now");
         edge_step();
         drive_write(TIME_BASE + 8'd2, 32'd1);
         check_outputs("time_now");
         // The DUT takes the control write on this edge
         edge_step();
         drive_idle();
         check_outputs("time_now");
         expect_time = value;
         for (k = 0; k < COUNT_CYCLES; k++) begin
            edge_step();
            drive_random_io();
            check_outputs("time_now");
            compare("time_now", "loaded time", expect_time, dut_vita_time);
            expect_time = expect_time + 64'd1;
         end
      end
      finish_test("time_now");
   endtask

   task automatic test_time_pps();
      radio_pkg::time_t value;
      int               rep;
      int               j;
      edge_step();
      drive_write(radio_pkg::SR_READBACK, {29'd0, radio_pkg::RB_TIME_PPS});
      check_outputs("time_pps");
      for (rep = 0; rep < PPS_REPS; rep++) begin
         value = {lcg_next(), lcg_next()};
         edge_step();
         drive_write(TIME_BASE, value[63:32]);
         check_outputs("time_pps");
         edge_step();
         drive_write(TIME_BASE + 8'd1, value[31:0]);
         check_outputs("time_pps");
         edge_step();
         drive_write(TIME_BASE + 8'd2, 32'd0);
         check_outputs("time_pps");
         for (j = 0; j < PPS_GAP; j++) begin
            edge_step();
            drive_idle();
            check_outputs("time_pps");
         end
         // The synchronizer flop puts the detected edge on the second clock
         for (j = 0; j < PPS_HIGH; j++) begin
            edge_step();
            pps <= 1'b1;
            check_outputs("time_pps");
            if (j == 2)
               compare("time_pps", "time at PPS", value, dut_vita_time);
         end
         for (j = 0; j < PPS_LOW; j++) begin
            edge_step();
            pps <= 1'b0;
            drive_random_io();
            check_outputs("time_pps");
         end
      end
      finish_test("time_pps");
   endtask

   task automatic test_readback_mix();
      logic [31:0] r;
      int          i;
      for (i = 0; i < N_MIX; i++) begin
         edge_step();
         r = lcg_next();
         drive_random_io();
         pps <= r[20];
         case (r[2:0])
            3'd0: drive_write(radio_pkg::SR_READBACK, {29'd0, radio_pkg::RB_FRONTEND});
            3'd1: drive_write(radio_pkg::SR_READBACK, {29'd0, radio_pkg::RB_STATUS});
            3'd2: drive_write(radio_pkg::SR_LOOPBACK, {31'd0, r[8]});
            3'd3: drive_write(radio_pkg::SR_CODEC_IDLE, lcg_next());
            3'd4: drive_write(radio_pkg::SR_READBACK, {29'd0, r[6:4]});
            default: drive_idle();
         endcase
         check_outputs("readback_mix");
      end
      finish_test("readback_mix");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      radio_clk    = 1'b0;
      rst          = 1'b1;
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      rx_word      = '0;
      fp_gpio      = '0;
      pps          = 1'b0;
      run_tx       = 1'b0;
      run_rx       = 1'b0;
      tx_strobe    = 1'b0;
      tx_sample    = '0;
      lcg_state    = 32'd49;
      test_checks  = 0;
      test_errors  = 0;
      total_checks = 0;
      total_errors = 0;
      tests_passed = 0;
      repeat (RESET_CYCLES) edge_step();
      rst <= 1'b0;
      test_register();
      test_tx_word();
      test_rx_word();
      test_time_now();
      test_time_pps();
      test_readback_mix();
      $display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
               tests_passed, TEST_COUNT, total_checks, total_errors);
      if (total_errors == 0 && tests_passed == TEST_COUNT)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 2 * CLK_HALF);
      $display("Watchdog timeout: the tests did not finish within %0d cycles",
               WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- verilog/radio_core.sv
// Radio clock domain core

`timescale 1ns/1ps

module radio_core #(
   parameter radio_pkg::set_addr_t SR_TIME_BASE = radio_pkg::SR_TIME
) (
   input  logic                            radio_clk,
   input  logic                            i_rst,
   // Settings bus
   input  logic                            i_set_stb,
   input  radio_pkg::set_addr_t            i_set_addr,
   input  radio_pkg::set_data_t            i_set_data,
   // Converter and pins
   input  radio_pkg::iq_t                  i_rx,
   input  logic [radio_pkg::FP_GPIO_W-1:0] i_fp_gpio,
   input  logic                            i_pps,
   // Run control and transmit sample
   input  logic                            i_run_tx,
   input  logic                            i_run_rx,
   input  logic                            i_tx_strobe,
   input  radio_pkg::iq_t                  i_tx_sample,
   output radio_pkg::iq_t                  o_tx,
   output radio_pkg::iq_t                  o_rx_sample,
   output logic                            o_rx_strobe,
   output radio_pkg::time_t                o_vita_time,
   output radio_pkg::rb_word_t             o_rb_data
);

   logic                 loopback;
   radio_pkg::set_data_t test_word;
   radio_pkg::iq_t       idle_word;
   radio_pkg::rb_sel_t   rb_sel;
   radio_pkg::time_t     time_value;
   logic                 time_load_now;
   logic                 time_load_pps;
   radio_pkg::time_t     vita_time_pps;

   //////////////////////////////////////////////////////////////////////
   // Settings and time
   //////////////////////////////////////////////////////////////////////

   radio_settings #(
      .SR_TIME_BASE    (SR_TIME_BASE)
   ) u_settings (
      .radio_clk       (radio_clk),
      .i_rst           (i_rst),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (i_set_addr),
      .i_set_data      (i_set_data),
      .o_loopback      (loopback),
      .o_test_word     (test_word),
      .o_idle_word     (idle_word),
      .o_rb_sel        (rb_sel),
      .o_time_value    (time_value),
      .o_time_load_now (time_load_now),
      .o_time_load_pps (time_load_pps)
   );

   timekeeper u_timekeeper (
      .radio_clk       (radio_clk),
      .i_rst           (i_rst),
      .i_pps           (i_pps),
      .i_time_value    (time_value),
      .i_load_now      (time_load_now),
      .i_load_pps      (time_load_pps),
      .o_vita_time     (o_vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

   //////////////////////////////////////////////////////////////////////
   // Front ends
   //////////////////////////////////////////////////////////////////////

   tx_frontend u_tx_frontend (
      .radio_clk   (radio_clk),
      .i_rst       (i_rst),
      .i_run_tx    (i_run_tx),
      .i_tx_strobe (i_tx_strobe),
      .i_tx_sample (i_tx_sample),
      .i_idle_word (idle_word),
      .o_tx        (o_tx)
   );

   // DAC word also feeds the loopback path
   rx_frontend u_rx_frontend (
      .radio_clk   (radio_clk),
      .i_rst       (i_rst),
      .i_run_rx    (i_run_rx),
      .i_loopback  (loopback),
      .i_rx        (i_rx),
      .i_tx        (o_tx),
      .i_fp_gpio   (i_fp_gpio),
      .o_rx_sample (o_rx_sample),
      .o_rx_strobe (o_rx_strobe)
   );

   readback_mux u_readback_mux (
      .radio_clk       (radio_clk),
      .i_rst           (i_rst),
      .i_rb_sel        (rb_sel),
      .i_test_word     (test_word),
      .i_vita_time     (o_vita_time),
      .i_vita_time_pps (vita_time_pps),
      .i_tx            (o_tx),
      .i_rx            (i_rx),
      .i_loopback      (loopback),
      .i_run_tx        (i_run_tx),
      .i_run_rx        (i_run_rx),
      .o_rb_data       (o_rb_data)
   );

endmodule

//--- verilog/readback_mux.sv
// Readback word selection

`timescale 1ns/1ps

module readback_mux (
   input  logic                 radio_clk,
   input  logic                 i_rst,
   input  radio_pkg::rb_sel_t   i_rb_sel,
   input  radio_pkg::set_data_t i_test_word,
   input  radio_pkg::time_t     i_vita_time,
   input  radio_pkg::time_t     i_vita_time_pps,
   input  radio_pkg::iq_t       i_tx,
   input  radio_pkg::iq_t       i_rx,
   input  logic                 i_loopback,
   input  logic                 i_run_tx,
   input  logic                 i_run_rx,
   output radio_pkg::rb_word_t  o_rb_data
);

   radio_pkg::rb_word_t rb_next;

   always_comb begin
      case (i_rb_sel)
         radio_pkg::RB_TEST:     rb_next = {32'd0, i_test_word};
         radio_pkg::RB_TIME:     rb_next = i_vita_time;
         radio_pkg::RB_TIME_PPS: rb_next = i_vita_time_pps;
         radio_pkg::RB_FRONTEND: rb_next = {i_tx, i_rx};
         radio_pkg::RB_STATUS:   rb_next = {61'd0, i_run_tx, i_run_rx, i_loopback};
         // Unused codes read zero
         default:                rb_next = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst)
         o_rb_data <= '0;
      else
         o_rb_data <= rb_next;
   end

endmodule

//--- verilog/rx_frontend.sv
// Receive word select and GPIO insertion

`timescale 1ns/1ps

module rx_frontend (
   input  logic                              radio_clk,
   input  logic                              i_rst,
   input  logic                              i_run_rx,
   input  logic                              i_loopback,
   input  radio_pkg::iq_t                    i_rx,
   input  radio_pkg::iq_t                    i_tx,
   input  logic [radio_pkg::FP_GPIO_W-1:0]   i_fp_gpio,
   output radio_pkg::iq_t                    o_rx_sample,
   output logic                              o_rx_strobe
);

   radio_pkg::iq_t rx_sel;
   logic           gpio_a;
   logic           gpio_b;

   // Digital loopback takes the DAC word back into the receive path
   assign rx_sel = i_loopback ? i_tx : i_rx;

   // Either connector can drive each bit
   assign gpio_a = i_fp_gpio[0] ^ i_fp_gpio[8];
   assign gpio_b = i_fp_gpio[1] ^ i_fp_gpio[9];

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx_sample <= '0;
         o_rx_strobe <= 1'b0;
      end else begin
         // I and Q LSBs carry the pin state
         o_rx_sample <= {rx_sel[31:17], gpio_a, rx_sel[15:1], gpio_b};
         o_rx_strobe <= i_run_rx;
      end
   end

endmodule

//--- verilog/tx_frontend.sv
// Transmit DAC word register

`timescale 1ns/1ps

module tx_frontend (
   input  logic           radio_clk,
   input  logic           i_rst,
   input  logic           i_run_tx,
   input  logic           i_tx_strobe,
   input  radio_pkg::iq_t i_tx_sample,
   input  radio_pkg::iq_t i_idle_word,
   output radio_pkg::iq_t o_tx
);

   radio_pkg::iq_t held_sample;
   radio_pkg::iq_t held_next;

   // A new strobe reaches the DAC in the same cycle it is held
   assign held_next = i_tx_strobe ? i_tx_sample : held_sample;

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         held_sample <= '0;
         o_tx        <= '0;
      end else begin
         held_sample <= held_next;
         // Idle pattern while the radio is stopped
         o_tx        <= i_run_tx ? held_next : i_idle_word;
      end
   end

endmodule

//--- verilog/timekeeper.sv
// Radio time counter

`timescale 1ns/1ps

module timekeeper (
   input  logic             radio_clk,
   input  logic             i_rst,
   input  logic             i_pps,
   input  radio_pkg::time_t i_time_value,
   input  logic             i_load_now,
   input  logic             i_load_pps,
   output radio_pkg::time_t o_vita_time,
   output radio_pkg::time_t o_vita_time_pps
);

   logic pps_sync;
   logic pps_prev;
   logic pps_edge;
   logic load_pending;

   assign pps_edge = pps_sync & ~pps_prev;

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         pps_sync        <= 1'b0;
         pps_prev        <= 1'b0;
         load_pending    <= 1'b0;
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
      end else begin
         pps_sync <= i_pps;
         pps_prev <= pps_sync;

         // Immediate load beats a pending PPS load
         if (i_load_now)
            o_vita_time <= i_time_value;
         else if (pps_edge && load_pending)
            o_vita_time <= i_time_value;
         else
            o_vita_time <= o_vita_time + 64'd1;

         if (pps_edge)
            o_vita_time_pps <= o_vita_time;

         // The latest request decides what stays pending
         if (i_load_now)
            load_pending <= 1'b0;
         else if (i_load_pps)
            load_pending <= 1'b1;
         else if (pps_edge)
            load_pending <= 1'b0;
      end
   end

endmodule

//--- verilog/radio_settings.sv
// Radio settings registers

`timescale 1ns/1ps

module radio_settings #(
   parameter radio_pkg::set_addr_t SR_TIME_BASE = radio_pkg::SR_TIME
) (
   input  logic                 radio_clk,
   input  logic                 i_rst,
   input  logic                 i_set_stb,
   input  radio_pkg::set_addr_t i_set_addr,
   input  radio_pkg::set_data_t i_set_data,
   output logic                 o_loopback,
   output radio_pkg::set_data_t o_test_word,
   output radio_pkg::iq_t       o_idle_word,
   output radio_pkg::rb_sel_t   o_rb_sel,
   output radio_pkg::time_t     o_time_value,
   output logic                 o_time_load_now,
   output logic                 o_time_load_pps
);

   localparam radio_pkg::set_addr_t ADDR_TIME_HI   = SR_TIME_BASE;
   localparam radio_pkg::set_addr_t ADDR_TIME_LO   = SR_TIME_BASE + 8'd1;
   localparam radio_pkg::set_addr_t ADDR_TIME_CTRL = SR_TIME_BASE + 8'd2;

   // Time halves wait here until the control word arrives
   radio_pkg::set_data_t time_hi;
   radio_pkg::set_data_t time_lo;

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_loopback      <= 1'b0;
         o_test_word     <= '0;
         o_idle_word     <= '0;
         o_rb_sel        <= '0;
         o_time_value    <= '0;
         o_time_load_now <= 1'b0;
         o_time_load_pps <= 1'b0;
         time_hi         <= '0;
         time_lo         <= '0;
      end else begin
         // Load pulses last a single cycle
         o_time_load_now <= 1'b0;
         o_time_load_pps <= 1'b0;
         if (i_set_stb) begin
            case (i_set_addr)
               radio_pkg::SR_LOOPBACK:   o_loopback  <= i_set_data[0];
               radio_pkg::SR_TEST:       o_test_word <= i_set_data;
               radio_pkg::SR_CODEC_IDLE: o_idle_word <= i_set_data;
               radio_pkg::SR_READBACK:   o_rb_sel    <= i_set_data[radio_pkg::RB_SEL_W-1:0];
               ADDR_TIME_HI:             time_hi     <= i_set_data;
               ADDR_TIME_LO:             time_lo     <= i_set_data;
               ADDR_TIME_CTRL: begin
                  o_time_value <= {time_hi, time_lo};
                  if (i_set_data[radio_pkg::TIME_CTRL_NOW])
                     o_time_load_now <= 1'b1;
                  else
                     o_time_load_pps <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

//--- verilog/radio_pkg.sv
// Radio core shared definitions

package radio_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   localparam int IQ_W       = 32;
   localparam int TIME_W     = 64;
   localparam int RB_W       = 64;
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_SEL_W   = 3;
   localparam int FP_GPIO_W  = 10;

   // I in the upper half, Q in the lower half
   typedef logic [IQ_W-1:0]       iq_t;
   typedef logic [TIME_W-1:0]     time_t;
   typedef logic [RB_W-1:0]       rb_word_t;
   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [RB_SEL_W-1:0]   rb_sel_t;

   //////////////////////////////////////////////////////////////////////
   // Settings bus addresses
   //////////////////////////////////////////////////////////////////////

   localparam set_addr_t SR_LOOPBACK   = 8'd6;
   localparam set_addr_t SR_TEST       = 8'd21;
   localparam set_addr_t SR_CODEC_IDLE = 8'd22;
   localparam set_addr_t SR_READBACK   = 8'd32;
   // Time high, low and control sit at base +0, +1, +2
   localparam set_addr_t SR_TIME       = 8'd128;

   // Control write bit that loads now when set and at the next PPS edge when clear
   localparam int TIME_CTRL_NOW = 0;

   //////////////////////////////////////////////////////////////////////
   // Readback selector codes
   //////////////////////////////////////////////////////////////////////

   localparam rb_sel_t RB_TEST     = 3'd0;
   localparam rb_sel_t RB_TIME     = 3'd1;
   localparam rb_sel_t RB_TIME_PPS = 3'd2;
   localparam rb_sel_t RB_FRONTEND = 3'd3;
   localparam rb_sel_t RB_STATUS   = 3'd5;

endpackage
